// File: src/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  // datapath word, also used for pc and instructions
  typedef logic [15:0] word_t;
  // register number
  typedef logic [3:0] reg_idx_t;
  // conditional branch offset, counted in halfwords
  typedef logic [8:0] br_off_t;
  // saved flags, z n v from msb down
  typedef logic [2:0] flags_t;

  localparam int FLAG_Z = 2;
  localparam int FLAG_N = 1;
  localparam int FLAG_V = 0;

  // opcode field, instr[15:12]
  typedef enum logic [3:0] {
    OP_ADD = 4'h0,
    OP_SUB = 4'h1,
    OP_XOR = 4'h2,
    OP_AND = 4'h3,
    OP_SLL = 4'h4,
    OP_SRA = 4'h5,
    OP_ROR = 4'h6,
    OP_OR  = 4'h7,
    OP_LW  = 4'h8,
    OP_SW  = 4'h9,
    OP_LLB = 4'hA,
    OP_LHB = 4'hB,
    OP_B   = 4'hC,
    OP_BR  = 4'hD,
    OP_NOP = 4'hE,
    OP_HLT = 4'hF
  } opcode_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_XOR,
    ALU_AND,
    ALU_SLL,
    ALU_SRA,
    ALU_ROR,
    ALU_OR,
    ALU_LLB,
    ALU_LHB
  } alu_op_t;

  typedef enum logic [1:0] {
    BR_NONE = 2'd0,
    BR_COND = 2'd1,
    BR_REG  = 2'd2,
    BR_HALT = 2'd3
  } branch_t;

  // condition field of B, instr[11:9]
  typedef enum logic [2:0] {
    COND_NE     = 3'd0,
    COND_EQ     = 3'd1,
    COND_GT     = 3'd2,
    COND_LT     = 3'd3,
    COND_GE     = 3'd4,
    COND_LE     = 3'd5,
    COND_OV     = 3'd6,
    COND_ALWAYS = 3'd7
  } cond_t;

endpackage

`default_nettype wire

// File: src/memory1c.sv
`timescale 1ns/1ns
`default_nettype none

module memory1c
  import cpu_pkg::*;
#(
  parameter int AW = 8
) (
  input  wire        clk,
  input  wire        rst_n,
  input  wire word_t addr,
  input  wire word_t data_in,
  input  wire        wr,
  output word_t      data_out
);

  localparam int DEPTH = 2 ** AW;

  word_t mem [DEPTH];
  logic [AW-1:0] word_addr;

  // byte address in, bit 0 dropped
  assign word_addr = addr[AW:1];

  // contents survive reset so a loaded program stays put
  // but nothing gets written while reset is held
  always_ff @(posedge clk) begin
    if (wr && rst_n) begin
      mem[word_addr] <= data_in;
    end
  end

  // async read, same cycle as the address
  assign data_out = mem[word_addr];

endmodule

`default_nettype wire

// File: src/control.sv
`timescale 1ns/1ns
`default_nettype none

module control
  import cpu_pkg::*;
(
  input  wire opcode_t opcode,
  output logic         reg_write,
  output logic         mem_write,
  output logic         mem_to_reg,
  output logic         alu_src_imm,
  output logic         z_en,
  output logic         nv_en,
  output alu_op_t      alu_op,
  output branch_t      branch
);

  always_comb begin
    // everything idle unless the opcode says otherwise
    reg_write   = 1'b0;
    mem_write   = 1'b0;
    mem_to_reg  = 1'b0;
    alu_src_imm = 1'b0;
    z_en        = 1'b0;
    nv_en       = 1'b0;
    alu_op      = ALU_ADD;
    branch      = BR_NONE;
    case (opcode)
      // register-register alu ops, z always, n/v for add and sub only
      OP_ADD, OP_SUB, OP_XOR, OP_AND, OP_OR: begin
        reg_write = 1'b1;
        z_en      = 1'b1;
        nv_en     = (opcode == OP_ADD) || (opcode == OP_SUB);
        alu_op    = alu_op_t'(opcode);
      end
      // shift amount comes from imm4
      OP_SLL, OP_SRA, OP_ROR: begin
        reg_write   = 1'b1;
        z_en        = 1'b1;
        alu_src_imm = 1'b1;
        alu_op      = alu_op_t'(opcode);
      end
      // address = rs + sext(imm4)
      OP_LW: begin
        reg_write   = 1'b1;
        mem_to_reg  = 1'b1;
        alu_src_imm = 1'b1;
      end
      OP_SW: begin
        mem_write   = 1'b1;
        alu_src_imm = 1'b1;
      end
      OP_LLB, OP_LHB: begin
        reg_write   = 1'b1;
        alu_src_imm = 1'b1;
        alu_op      = (opcode == OP_LLB) ? ALU_LLB : ALU_LHB;
      end
      OP_B:    branch = BR_COND;
      OP_BR:   branch = BR_REG;
      OP_HLT:  branch = BR_HALT;
      // nop falls through to the idle defaults
      default: branch = BR_NONE;
    endcase
  end

endmodule

`default_nettype wire

// File: src/register_file.sv
`timescale 1ns/1ns
`default_nettype none

module register_file
  import cpu_pkg::*;
(
  input  wire           clk,
  input  wire           rst_n,
  input  wire reg_idx_t src1,
  input  wire reg_idx_t src2,
  input  wire reg_idx_t dst,
  input  wire           write,
  input  wire word_t    dst_data,
  output word_t         src1_data,
  output word_t         src2_data
);

  word_t regs [16];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else if (write && (dst != '0)) begin
      // r0 writes are dropped here
      regs[dst] <= dst_data;
    end
  end

  // both read ports async, r0 forced to zero
  assign src1_data = (src1 == '0) ? '0 : regs[src1];
  assign src2_data = (src2 == '0) ? '0 : regs[src2];

  // r0 storage itself must stay clear, whatever the trace reported
  r0_stays_zero: assert property (
    @(posedge clk) disable iff (!rst_n)
    regs[0] == '0
  );

endmodule

`default_nettype wire

// File: src/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu
  import cpu_pkg::*;
(
  input  wire word_t   a,
  input  wire word_t   b,
  input  wire alu_op_t op,
  output word_t        result,
  output logic         z,
  output logic         n,
  output logic         v
);

  word_t       sum;
  word_t       diff;
  logic [3:0]  sh;
  logic [31:0] rot;

  // shift and rotate amounts use the low nibble only
  assign sh   = b[3:0];
  assign sum  = a + b;
  assign diff = a - b;
  // doubled word shifted right, low half is the rotate
  assign rot  = {a, a} >> sh;

  always_comb begin
    v = 1'b0;
    case (op)
      ALU_ADD: begin
        result = sum;
        // same operand signs, result sign flipped
        v = (a[15] == b[15]) && (sum[15] != a[15]);
      end
      ALU_SUB: begin
        result = diff;
        v = (a[15] != b[15]) && (diff[15] != a[15]);
      end
      ALU_XOR: result = a ^ b;
      ALU_AND: result = a & b;
      ALU_OR:  result = a | b;
      ALU_SLL: result = a << sh;
      ALU_SRA: result = word_t'($signed(a) >>> sh);
      ALU_ROR: result = rot[15:0];
      // keep high byte of rd, take imm8 low
      ALU_LLB: result = {a[15:8], b[7:0]};
      // imm8 high, low byte of rd kept
      ALU_LHB: result = {b[7:0], a[7:0]};
      default: result = sum;
    endcase
  end

  // raw flags, flag_reg decides what sticks
  assign z = (result == '0);
  assign n = result[15];

endmodule

`default_nettype wire

// File: src/flag_reg.sv
`timescale 1ns/1ns
`default_nettype none

module flag_reg
  import cpu_pkg::*;
(
  input  wire clk,
  input  wire rst_n,
  input  wire stall,
  input  wire z_en,
  input  wire nv_en,
  input  wire z_in,
  input  wire n_in,
  input  wire v_in,
  output flags_t flags
);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      flags <= '0;
    end else if (!stall) begin
      // z follows every alu op
      if (z_en) begin
        flags[FLAG_Z] <= z_in;
      end
      // n and v only from add/sub, so xor etc. leave them alone
      if (nv_en) begin
        flags[FLAG_N] <= n_in;
        flags[FLAG_V] <= v_in;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/pc_control.sv
`timescale 1ns/1ns
`default_nettype none

module pc_control
  import cpu_pkg::*;
(
  input  wire          clk,
  input  wire          rst_n,
  input  wire          stall,
  input  wire branch_t branch,
  input  wire cond_t   cond,
  input  wire br_off_t offset,
  input  wire word_t   reg_target,
  input  wire flags_t  flags,
  output word_t        pc,
  output logic         hlt
);

  logic  halted_q;
  logic  taken;
  word_t pc_plus2;
  word_t next_pc;

  always_comb begin
    case (cond)
      COND_NE: taken = !flags[FLAG_Z];
      COND_EQ: taken = flags[FLAG_Z];
      COND_GT: taken = !flags[FLAG_Z] && !flags[FLAG_N];
      COND_LT: taken = flags[FLAG_N];
      COND_GE: taken = flags[FLAG_Z] || !flags[FLAG_N];
      COND_LE: taken = flags[FLAG_Z] || flags[FLAG_N];
      COND_OV: taken = flags[FLAG_V];
      default: taken = 1'b1;
    endcase
  end

  assign pc_plus2 = pc + 16'd2;

  always_comb begin
    case (branch)
      // offset is in halfwords, relative to pc + 2
      BR_COND: next_pc = taken ? pc_plus2 + {{6{offset[8]}}, offset, 1'b0} : pc_plus2;
      // register target, low bit masked to keep word alignment
      BR_REG:  next_pc = {reg_target[15:1], 1'b0};
      BR_HALT: next_pc = pc;
      default: next_pc = pc_plus2;
    endcase
  end

  // high as soon as hlt is fetched, sticky until reset
  assign hlt = halted_q || ((branch == BR_HALT) && !stall);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc       <= '0;
      halted_q <= 1'b0;
    end else if (!stall && !hlt) begin
      pc <= next_pc;
    end else if (!stall) begin
      halted_q <= 1'b1;
    end
  end

  pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc[0] == 1'b0);

  // once halted the core must sit on the hlt word
  pc_frozen_in_halt: assert property (
    @(posedge clk) disable iff (!rst_n)
    hlt |=> $stable(pc)
  );

endmodule

`default_nettype wire

// File: src/cpu.sv
`timescale 1ns/1ns
`default_nettype none

module cpu
  import cpu_pkg::*;
#(
  parameter int IMEM_AW = 8,
  parameter int DMEM_AW = 8
) (
  input  wire        clk,
  input  wire        rst_n,
  input  wire        load_en,
  input  wire word_t load_addr,
  input  wire word_t load_data,
  output logic       hlt,
  output word_t      pc,
  output logic       wb_en,
  output reg_idx_t   wb_reg,
  output word_t      wb_data
);

  word_t    instr;
  word_t    imem_addr;
  opcode_t  opcode;
  reg_idx_t rd;
  reg_idx_t rs;
  reg_idx_t rt;
  reg_idx_t src1_sel;
  reg_idx_t src2_sel;
  logic     byte_load;

  logic     reg_write;
  logic     mem_write;
  logic     mem_to_reg;
  logic     alu_src_imm;
  logic     z_en;
  logic     nv_en;
  alu_op_t  alu_op;
  branch_t  branch;

  word_t    src1_data;
  word_t    src2_data;
  word_t    imm;
  word_t    alu_b;
  word_t    alu_result;
  word_t    mem_rdata;
  word_t    wb_value;
  logic     alu_z;
  logic     alu_n;
  logic     alu_v;
  flags_t   flags;

  // fetch port is borrowed by the loader while load_en is high
  assign imem_addr = load_en ? load_addr : pc;

  memory1c #(.AW(IMEM_AW)) instr_mem (
    .clk(clk), .rst_n(rst_n), .addr(imem_addr), .data_in(load_data),
    .wr(load_en), .data_out(instr)
  );

  // instruction fields
  assign opcode    = opcode_t'(instr[15:12]);
  assign rd        = instr[11:8];
  assign rs        = instr[7:4];
  assign rt        = instr[3:0];
  assign byte_load = (opcode == OP_LLB) || (opcode == OP_LHB);

  control ctrl (
    .opcode(opcode), .reg_write(reg_write), .mem_write(mem_write),
    .mem_to_reg(mem_to_reg), .alu_src_imm(alu_src_imm), .z_en(z_en),
    .nv_en(nv_en), .alu_op(alu_op), .branch(branch)
  );

  // llb/lhb modify rd in place, sw stores rd
  assign src1_sel = byte_load ? rd : rs;
  assign src2_sel = (opcode == OP_SW) ? rd : rt;

  register_file regs (
    .clk(clk), .rst_n(rst_n), .src1(src1_sel), .src2(src2_sel), .dst(rd),
    .write(reg_write && !load_en), .dst_data(wb_value),
    .src1_data(src1_data), .src2_data(src2_data)
  );

  // imm8 zero-extended for byte loads, sext imm4 otherwise
  assign imm   = byte_load ? {8'h00, instr[7:0]} : {{12{instr[3]}}, instr[3:0]};
  assign alu_b = alu_src_imm ? imm : src2_data;

  alu alu_i (
    .a(src1_data), .b(alu_b), .op(alu_op), .result(alu_result),
    .z(alu_z), .n(alu_n), .v(alu_v)
  );

  flag_reg flag_i (
    .clk(clk), .rst_n(rst_n), .stall(load_en), .z_en(z_en), .nv_en(nv_en),
    .z_in(alu_z), .n_in(alu_n), .v_in(alu_v), .flags(flags)
  );

  // alu result is the byte address for lw/sw
  memory1c #(.AW(DMEM_AW)) data_mem (
    .clk(clk), .rst_n(rst_n), .addr(alu_result), .data_in(src2_data),
    .wr(mem_write && !load_en), .data_out(mem_rdata)
  );

  pc_control pc_i (
    .clk(clk), .rst_n(rst_n), .stall(load_en), .branch(branch),
    .cond(cond_t'(instr[11:9])), .offset(instr[8:0]), .reg_target(src1_data),
    .flags(flags), .pc(pc), .hlt(hlt)
  );

  assign wb_value = mem_to_reg ? mem_rdata : alu_result;

  // trace shows the write about to commit, r0 included
  assign wb_en   = reg_write && !load_en;
  assign wb_reg  = rd;
  assign wb_data = wb_value;

endmodule

`default_nettype wire

// File: verification/cpu_checker.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_checker
  import cpu_pkg::*;
#(
  parameter word_t HALT_PC = 16'h005E
) (
  input  wire           clk,
  input  wire           rst_n,
  input  wire           load_en,
  input  wire           hlt,
  input  wire word_t    pc,
  input  wire           wb_en,
  input  wire reg_idx_t wb_reg,
  input  wire word_t    wb_data,
  output int            errors
);

  localparam int N_WB = 18;

  // expected register writes in program order as {reg, data}
  localparam logic [19:0] EXPECTED [N_WB] = '{
    20'h1_0034, 20'h1_1234, 20'h2_00FF, 20'h2_7FFF, 20'h3_0001,
    20'h4_8000, 20'h5_6DCB, 20'h6_1234, 20'h7_1235, 20'h8_2340,
    20'h9_0000, 20'hA_F000, 20'hB_4123, 20'hC_8002, 20'hD_1234,
    20'h0_2468, 20'hE_0001, 20'hF_005A
  };

  int   idx = 0;
  int   error_count = 0;
  logic halt_seen = 1'b0;

  assign errors = error_count;

  // sampled mid-cycle well clear of the edge and the input updates
  always @(negedge clk) begin
    if (!rst_n || load_en) begin
      // core must sit idle at pc 0 while reset or the loader owns it
      if (pc !== 16'h0000) begin
        $display("MISMATCH pc: got %h expected %h (reset/load)", pc, 16'h0000);
        error_count = error_count + 1;
      end
      if (hlt !== 1'b0) begin
        $display("hlt went high during reset or program load");
        error_count = error_count + 1;
      end
      if (wb_en !== 1'b0) begin
        $display("wb_en went high during reset or program load");
        error_count = error_count + 1;
      end
    end else begin
      if (wb_en === 1'b1) begin
        if (halt_seen || idx >= N_WB) begin
          $display("extra writeback to r%0d with data %h after the trace ended",
                   wb_reg, wb_data);
          error_count = error_count + 1;
        end else begin
          if (wb_reg !== EXPECTED[idx][19:16]) begin
            $display("MISMATCH wb_reg: got %h expected %h (entry %0d)",
                     wb_reg, EXPECTED[idx][19:16], idx);
            error_count = error_count + 1;
          end
          if (wb_data !== EXPECTED[idx][15:0]) begin
            $display("MISMATCH wb_data: got %h expected %h (entry %0d)",
                     wb_data, EXPECTED[idx][15:0], idx);
            error_count = error_count + 1;
          end
          idx = idx + 1;
        end
      end
      if (hlt === 1'b1 && !halt_seen) begin
        // every expected write must be in before the core stops
        if (idx != N_WB) begin
          $display("missing writeback at halt, %0d of %0d entries seen", idx, N_WB);
          error_count = error_count + 1;
        end
        halt_seen = 1'b1;
      end
      if (halt_seen) begin
        // hlt is sticky and the pc stays on the hlt word
        if (hlt !== 1'b1) begin
          $display("hlt dropped after the core halted");
          error_count = error_count + 1;
        end
        if (pc !== HALT_PC) begin
          $display("MISMATCH pc: got %h expected %h (halted)", pc, HALT_PC);
          error_count = error_count + 1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: verification/cpu_tb.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_tb
  import cpu_pkg::*;
();

  localparam int N_PROG = 48;
  localparam int HALT_WAIT = 400;
  localparam int HOLD_CYCLES = 20;

  // word i sits at byte address 2*i
  localparam word_t PROG [N_PROG] = '{
    // words 0 to 4 build r1 = 1234, r2 = 7fff and r3 = 0001 with llb/lhb
    16'hA134, 16'hB112, 16'hA2FF, 16'hB27F, 16'hA301,
    // word 5 add wraps to 8000 with n and v set so b ov skips word 7
    16'h0423, 16'hCC01, 16'hA5EE,
    // word 8 xor keeps n and v so b ov skips word 10
    16'h2512, 16'hCC01, 16'hA500,
    // word 11 on z=0 n=1 so eq gt ge all fall through
    16'hC201, 16'h3612, 16'hC401, 16'h7713, 16'hC801, 16'h4814,
    // word 17 sub to zero so eq skips word 19 and ne falls through
    16'h1911, 16'hC201, 16'hA955, 16'hC001,
    // word 21 sra leaves z=0 n=0 so gt ne ge each skip one word
    16'h5A43, 16'hC401, 16'hAA11, 16'hC001, 16'hAA22, 16'hC801, 16'hAA33,
    // word 28 ror then le ov lt fall through and a taken one would skip the sub
    16'h6B14, 16'hCA03, 16'hCC02, 16'hC601,
    // word 32 sub to 8002 sets n so le and lt are taken
    16'h1C32, 16'hCA01, 16'hAC44, 16'hC601, 16'hAC55,
    // word 37 sw r1 to byte 4 and lw it back into r13
    16'h9133, 16'h8D33,
    // word 39 writes r0 then r14 = r0 + r3 should be 1
    16'h0011, 16'h0E03,
    // word 41 sets r15 = 005a and br jumps to the b always at word 45
    16'hAF5A, 16'hD0F0, 16'hAF99, 16'hAF98, 16'hCE01, 16'hA1FF,
    // word 47 hlt at byte 005e
    16'hF000
  };

  logic     clk = 1'b0;
  logic     rst_n;
  logic     load_en;
  word_t    load_addr;
  word_t    load_data;
  logic     hlt;
  word_t    pc;
  logic     wb_en;
  reg_idx_t wb_reg;
  word_t    wb_data;
  int       checker_errors;
  int       timeout_errors;
  int       cyc;

  cpu UUT (
    .clk(clk), .rst_n(rst_n), .load_en(load_en), .load_addr(load_addr),
    .load_data(load_data), .hlt(hlt), .pc(pc), .wb_en(wb_en),
    .wb_reg(wb_reg), .wb_data(wb_data)
  );

  cpu_checker #(.HALT_PC(16'h005E)) checker_i (
    .clk(clk), .rst_n(rst_n), .load_en(load_en), .hlt(hlt), .pc(pc),
    .wb_en(wb_en), .wb_reg(wb_reg), .wb_data(wb_data), .errors(checker_errors)
  );

  initial begin
    forever #20 clk = ~clk;
  end

  initial begin
    // reset and stall from time zero
    rst_n = 1'b0;
    load_en = 1'b1;
    load_addr = '0;
    load_data = '0;
    timeout_errors = 0;
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;
    // one word per edge into instruction memory
    for (int i = 0; i < N_PROG; i++) begin
      load_addr = word_t'(2 * i);
      load_data = PROG[i];
      @(posedge clk);
      #2;
    end
    load_en = 1'b0;
    load_addr = '0;
    load_data = '0;
    // run until hlt or the cycle limit
    cyc = 0;
    while (hlt !== 1'b1 && cyc < HALT_WAIT) begin
      @(negedge clk);
      cyc++;
    end
    if (hlt !== 1'b1) begin
      $display("timeout, hlt not seen within %0d cycles", HALT_WAIT);
      timeout_errors++;
    end
    // halted core should sit still while the checker keeps watching
    repeat (HOLD_CYCLES) @(negedge clk);
    @(posedge clk);
    $display("errors: checker %0d, timeout %0d", checker_errors, timeout_errors);
    if (checker_errors + timeout_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
src/cpu_pkg.sv
src/memory1c.sv
src/control.sv
src/register_file.sv
src/alu.sv
src/flag_reg.sv
src/pc_control.sv
src/cpu.sv
verification/cpu_checker.sv
verification/cpu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# verilator build and run of cpu_tb, verdict taken from sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module cpu_tb -Mdir obj_dir -o cpu_sim -f project.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/cpu_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "simulation exited with an error, see sim.log"
  exit 1
fi

if grep -q "TESTBENCH FAILED" sim.log; then
  echo "failure reported in sim.log"
  exit 1
fi
echo "no failure reported in sim.log"
exit 0
